// ==== design/sd_crypt_pkg.sv ====
// SD crypt package: shared widths, block constants, line bus and driver states
package sd_crypt_pkg;

	//==================================================
	// Widths with a meaning
	//==================================================
	typedef logic [3:0]  nibble_t;   // One sample of DAT[3:0]
	typedef logic [9:0]  ram_addr_t; // Nibble index inside a block
	typedef logic [15:0] crc_t;      // Per-line CRC16 remainder
	typedef logic [15:0] key_t;      // Cipher key and LFSR state

	//==================================================
	// Block format
	//==================================================
	localparam int BLOCK_NIBBLES = 1024; // Data nibbles per block
	localparam int CRC_BITS      = 16;   // CRC nibbles per block

	// CCITT polynomial x^16+x^12+x^5+1, top bit implied
	localparam crc_t CRC_POLY = 16'h1021;

	// LFSR must never start from all zeros
	localparam key_t LFSR_ZERO_SEED = 16'hACE1;

	// Lines as driven by the card side
	typedef struct packed {
		logic    oe;   // Drive enable
		nibble_t data; // Value on DAT[3:0]
	} sd_lines_t;

	// Gray-style encoding, neighbouring states differ in one bit
	typedef enum logic [2:0] {
		IDLE      = 3'b000,
		RECV_DATA = 3'b001,
		CHECK_CRC = 3'b011,
		WAIT_DATA = 3'b010,
		SEND_DATA = 3'b110,
		SEND_CRC  = 3'b100
	} drv_state_t;

endpackage

// ==== design/crc16_line.sv ====
// Serial CRC16 of one SD data line, with unload mode that shifts the remainder out MSB first
module crc16_line
	import sd_crypt_pkg::*;
(
	input  logic iclk,
	input  logic clr,    // Sync clear, also active in idle states
	input  logic din,    // Serial data, first bit first
	input  logic unload, // Shift remainder out instead of dividing
	output logic crc_bit // Remainder MSB
);

	crc_t crc_q;
	logic fb;

	// Feedback of the division
	assign fb = din ^ crc_q[15];

	always_ff @(posedge iclk)
	begin
		if (clr)
		begin
			crc_q <= '0;
		end
		else if (unload)
		begin
			// Plain shift, remainder walks out at the top
			crc_q <= {crc_q[14:0], 1'b0};
		end
		else if (fb)
		begin
			crc_q <= {crc_q[14:0], 1'b0} ^ CRC_POLY;
		end
		else
		begin
			crc_q <= {crc_q[14:0], 1'b0};
		end
	end

	assign crc_bit = crc_q[15];

endmodule

// ==== design/nibble_ram.sv ====
// Block RAM of 1024 nibbles, synchronous write and registered read
module nibble_ram
	import sd_crypt_pkg::*;
(
	input  logic      iclk,

	input  logic      we,
	input  ram_addr_t waddr,
	input  nibble_t   wdata,

	input  ram_addr_t raddr,
	output nibble_t   rdata // Valid one cycle after raddr
);

	nibble_t mem [BLOCK_NIBBLES];
	nibble_t rdata_q;

	always_ff @(posedge iclk)
	begin
		if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	// Read-before-write on an address clash
	always_ff @(posedge iclk)
	begin
		rdata_q <= mem[raddr];
	end

	assign rdata = rdata_q;

endmodule

// ==== design/nibble_cipher.sv ====
// Nibble cipher: XORs the received block with an LFSR keystream into the transmit RAM
module nibble_cipher
	import sd_crypt_pkg::*;
(
	input  logic      iclk,
	input  logic      irst,

	input  logic      start, // Block is in the receive RAM
	input  key_t      key,

	// Receive RAM read port
	output ram_addr_t rd_addr,
	input  nibble_t   rd_data,

	// Transmit RAM write port
	output ram_addr_t wr_addr,
	output nibble_t   wr_data,
	output logic      wr_en,

	output logic      done // One cycle after the last write
);

	logic      busy;
	ram_addr_t rd_cnt;
	ram_addr_t wr_addr_q;
	logic      wr_en_q;
	logic      done_q;
	key_t      lfsr;
	logic      lfsr_fb;

	// Taps 16, 14, 13, 11
	assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	always_ff @(posedge iclk)
	begin
		if (irst)
		begin
			busy    <= 1'b0;
			rd_cnt  <= '0;
			wr_en_q <= 1'b0;
			done_q  <= 1'b0;
		end
		else
		begin
			wr_en_q <= busy; // Data returns one cycle after the read
			done_q  <= wr_en_q && (wr_addr_q == ram_addr_t'(BLOCK_NIBBLES - 1));

			if (start)
			begin
				busy   <= 1'b1;
				rd_cnt <= '0;
			end
			else if (busy)
			begin
				rd_cnt <= rd_cnt + 10'd1;
				if (rd_cnt == ram_addr_t'(BLOCK_NIBBLES - 1))
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge iclk)
	begin
		wr_addr_q <= rd_cnt;
		if (start)
			lfsr <= (key == '0) ? LFSR_ZERO_SEED : key;
		else if (wr_en_q)
			lfsr <= {lfsr[14:0], lfsr_fb}; // Next keystream nibble
	end

	assign rd_addr = rd_cnt;
	assign wr_addr = wr_addr_q;
	assign wr_data = rd_data ^ lfsr[3:0];
	assign wr_en   = wr_en_q;
	assign done    = done_q;

endmodule

// ==== design/sd_data_lines.sv ====
// SD data line driver: receives a block, checks its CRCs, waits for the cipher and sends it back
module sd_data_lines
	import sd_crypt_pkg::*;
(
	input  logic      iclk,
	input  logic      irst,

	input  nibble_t   sd_in,   // DAT[3:0] from the host
	output sd_lines_t sd_out,  // DAT[3:0] towards the host

	input  logic      arm,     // Accept a start bit in IDLE
	input  logic      send,    // Processed block is ready

	// Receive RAM write port
	output ram_addr_t rx_addr,
	output nibble_t   rx_data,
	output logic      rx_we,

	// Transmit RAM read port, one cycle latency
	output ram_addr_t tx_addr,
	input  nibble_t   tx_data,

	output logic      proc_start, // Starts the cipher
	output logic      crc_fail,
	output logic      idle
);

	drv_state_t  state;
	logic [10:0] counter;
	nibble_t     data_q;       // Line nibble, in and out
	ram_addr_t   rx_addr_q;
	logic        rx_we_q;
	logic        crc_fail_q;
	logic        proc_start_q;

	logic        crc_clr;
	logic        crc_unload;
	nibble_t     crc_din;
	nibble_t     crc_nibble;   // Current CRC bit of each line

	//==================================================
	// Per-line CRC units
	//==================================================
	assign idle       = (state == IDLE) || (state == WAIT_DATA);
	assign crc_clr    = irst || idle;
	assign crc_unload = (state == CHECK_CRC) || (state == SEND_CRC);

	// Outgoing data is fed as it is fetched, incoming as it arrives
	assign crc_din = (state == SEND_DATA) ? tx_data : sd_in;

	for (genvar i = 0; i < 4; i++)
	begin : g_crc
		crc16_line crc_i
		(
			.iclk    (iclk),
			.clr     (crc_clr),
			.din     (crc_din[i]),
			.unload  (crc_unload),
			.crc_bit (crc_nibble[i])
		);
	end

	//==================================================
	// State machine
	//==================================================
	always_ff @(posedge iclk)
	begin
		if (irst)
		begin
			state        <= IDLE;
			counter      <= '0;
			rx_we_q      <= 1'b0;
			crc_fail_q   <= 1'b0;
			proc_start_q <= 1'b0;
		end
		else
		begin
			proc_start_q <= 1'b0;
			rx_we_q      <= (state == RECV_DATA); // Write lags the sample by one cycle

			case (state)
				IDLE:
				begin
					if (arm && sd_in == 4'h0) // Start bit on all lines
					begin
						state      <= RECV_DATA;
						counter    <= '0;
						crc_fail_q <= 1'b0;
					end
				end

				RECV_DATA:
				begin
					counter <= counter + 11'd1;
					if (counter == 11'(BLOCK_NIBBLES - 1))
					begin
						state   <= CHECK_CRC;
						counter <= '0;
					end
				end

				CHECK_CRC: // Remainder against received CRC
				begin
					if (crc_nibble != sd_in)
					begin
						state      <= IDLE;
						crc_fail_q <= 1'b1;
					end
					else if (counter == 11'(CRC_BITS - 1))
					begin
						state        <= WAIT_DATA;
						counter      <= '0;
						proc_start_q <= 1'b1;
					end
					else
					begin
						counter <= counter + 11'd1;
					end
				end

				WAIT_DATA:
				begin
					if (send)
					begin
						state   <= SEND_DATA;
						counter <= '0;
					end
				end

				SEND_DATA:
				begin
					counter <= counter + 11'd1;
					if (counter == 11'(BLOCK_NIBBLES - 1))
					begin
						state   <= SEND_CRC;
						counter <= '0;
					end
				end

				SEND_CRC: // CRC nibbles, then end bit
				begin
					counter <= counter + 11'd1;
					if (counter == 11'(CRC_BITS + 1))
					begin
						state   <= IDLE;
						counter <= '0;
					end
				end

				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	//==================================================
	// Line register and RAM address
	//==================================================
	always_ff @(posedge iclk)
	begin
		rx_addr_q <= counter[9:0];
		case (state)
			WAIT_DATA: data_q <= 4'h0;    // Start bit
			SEND_DATA: data_q <= tx_data;
			SEND_CRC:
			begin
				if (counter < 11'(CRC_BITS))
					data_q <= crc_nibble;
				else
					data_q <= 4'hF;        // End bit
			end
			default:   data_q <= sd_in;
		endcase
	end

	// One address ahead, so the registered read lines up
	assign tx_addr = (state == SEND_DATA) ? counter[9:0] + 10'd1 : '0;

	always_comb
	begin
		sd_out.oe   = (state == SEND_DATA) || (state == SEND_CRC);
		sd_out.data = data_q;
	end

	assign rx_addr    = rx_addr_q;
	assign rx_data    = data_q;
	assign rx_we      = rx_we_q;
	assign proc_start = proc_start_q;
	assign crc_fail   = crc_fail_q;

endmodule

// ==== design/sd_crypt_top.sv ====
// SD crypt bridge top: line driver, receive and transmit RAMs and nibble cipher
module sd_crypt_top
	import sd_crypt_pkg::*;
(
	input  logic      iclk,
	input  logic      irst,

	input  nibble_t   sd_in,
	output sd_lines_t sd_out,

	input  logic      arm,
	input  key_t      key,

	output logic      crc_fail,
	output logic      idle
);

	// Driver to receive RAM
	ram_addr_t rx_addr;
	nibble_t   rx_data;
	logic      rx_we;

	// Transmit RAM to driver
	ram_addr_t tx_addr;
	nibble_t   tx_data;

	// Cipher side
	ram_addr_t ciph_rd_addr;
	nibble_t   ciph_rd_data;
	ram_addr_t ciph_wr_addr;
	nibble_t   ciph_wr_data;
	logic      ciph_wr_en;
	logic      proc_start;
	logic      proc_done;

	sd_data_lines sd_data_lines_i
	(
		.iclk       (iclk),
		.irst       (irst),
		.sd_in      (sd_in),
		.sd_out     (sd_out),
		.arm        (arm),
		.send       (proc_done),
		.rx_addr    (rx_addr),
		.rx_data    (rx_data),
		.rx_we      (rx_we),
		.tx_addr    (tx_addr),
		.tx_data    (tx_data),
		.proc_start (proc_start),
		.crc_fail   (crc_fail),
		.idle       (idle)
	);

	nibble_ram rx_ram_i
	(
		.iclk  (iclk),
		.we    (rx_we),
		.waddr (rx_addr),
		.wdata (rx_data),
		.raddr (ciph_rd_addr),
		.rdata (ciph_rd_data)
	);

	nibble_ram tx_ram_i
	(
		.iclk  (iclk),
		.we    (ciph_wr_en),
		.waddr (ciph_wr_addr),
		.wdata (ciph_wr_data),
		.raddr (tx_addr),
		.rdata (tx_data)
	);

	nibble_cipher nibble_cipher_i
	(
		.iclk    (iclk),
		.irst    (irst),
		.start   (proc_start),
		.key     (key),
		.rd_addr (ciph_rd_addr),
		.rd_data (ciph_rd_data),
		.wr_addr (ciph_wr_addr),
		.wr_data (ciph_wr_data),
		.wr_en   (ciph_wr_en),
		.done    (proc_done)
	);

endmodule

// ==== verif/sd_host_model.sv ====
// SD host model: sends a data block with per-line CRCs and captures the block sent back
module sd_host_model
	import sd_crypt_pkg::*;
(
	input  logic      iclk,
	output nibble_t   host_dat,  // DAT[3:0] towards the card
	input  sd_lines_t card_lines // DAT[3:0] from the card
);

	timeunit 1ns;
	timeprecision 1ns;

	nibble_t tx_block [BLOCK_NIBBLES];
	nibble_t rx_block [BLOCK_NIBBLES];
	nibble_t rx_start;
	nibble_t rx_end;
	crc_t    rx_crc   [4]; // CRC as returned, per line
	crc_t    calc_crc [4]; // Recomputed over rx_block
	int      oe_drops;
	logic    oe_after;
	logic    timed_out;

	initial host_dat = 4'hF; // Pull-ups, lines idle high

	// One bit of the CCITT division, MSB out first
	function automatic crc_t crc_step(crc_t c, logic b);
		crc_t nxt;
		nxt = {c[14:0], 1'b0};
		if (b ^ c[15])
			nxt = nxt ^ CRC_POLY;
		return nxt;
	endfunction

	task automatic fill_block(inout int seed);
		for (int k = 0; k < BLOCK_NIBBLES; k++)
			tx_block[k] = nibble_t'($random(seed));
	endtask

	task automatic drive_nibble(input nibble_t n);
		@(posedge iclk);
		#2 host_dat = n;
	endtask

	//==================================================
	// Block out, bad_crc < 0 keeps all CRCs intact
	//==================================================
	task automatic send_block(input int bad_crc);
		crc_t    line_crc [4];
		nibble_t nib;
		for (int i = 0; i < 4; i++)
			line_crc[i] = '0;
		for (int k = 0; k < BLOCK_NIBBLES; k++)
			for (int i = 0; i < 4; i++)
				line_crc[i] = crc_step(line_crc[i], tx_block[k][i]);
		drive_nibble(4'h0); // Start bit
		for (int k = 0; k < BLOCK_NIBBLES; k++)
			drive_nibble(tx_block[k]);
		for (int j = 0; j < CRC_BITS; j++)
		begin
			for (int i = 0; i < 4; i++)
				nib[i] = line_crc[i][15 - j];
			if (j == bad_crc)
				nib = nib ^ 4'h1; // Flip line 0 only
			drive_nibble(nib);
		end
		drive_nibble(4'hF); // End bit
		drive_nibble(4'hF);
	endtask

	// Returned nibble, taken mid-cycle
	task automatic next_sample(output nibble_t n);
		@(negedge iclk);
		if (!card_lines.oe)
			oe_drops++;
		n = card_lines.data;
	endtask

	task automatic capture_block(input int limit);
		int      waited;
		nibble_t nib;
		waited    = 0;
		oe_drops  = 0;
		timed_out = 1'b0;
		@(negedge iclk);
		while (!card_lines.oe && waited < limit)
		begin
			@(negedge iclk);
			waited++;
		end
		if (!card_lines.oe)
		begin
			timed_out = 1'b1;
			return;
		end
		rx_start = card_lines.data;
		for (int k = 0; k < BLOCK_NIBBLES; k++)
		begin
			next_sample(nib);
			rx_block[k] = nib;
		end
		for (int j = 0; j < CRC_BITS; j++)
		begin
			next_sample(nib);
			for (int i = 0; i < 4; i++)
				rx_crc[i][15 - j] = nib[i];
		end
		next_sample(rx_end);
		@(negedge iclk);
		oe_after = card_lines.oe; // Bus released
		for (int i = 0; i < 4; i++)
		begin
			calc_crc[i] = '0;
			for (int k = 0; k < BLOCK_NIBBLES; k++)
				calc_crc[i] = crc_step(calc_crc[i], rx_block[k][i]);
		end
	endtask

endmodule

// ==== verif/sd_crypt_tb.sv ====
// Testbench for the SD crypt bridge: random blocks, a CRC error and the zero key case
module sd_crypt_tb
	import sd_crypt_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ns;

	logic      iclk = 1'b0;
	logic      irst;
	logic      arm;
	key_t      key;
	nibble_t   sd_in;
	sd_lines_t sd_out;
	logic      crc_fail;
	logic      idle;

	int        seed = 51008;
	int        errors;
	int        checks;
	logic      stop_run; // Set on a timeout
	string     test_name;

	always #10 iclk = ~iclk;

	sd_crypt_top sd_crypt_top_i
	(
		.iclk     (iclk),
		.irst     (irst),
		.sd_in    (sd_in),
		.sd_out   (sd_out),
		.arm      (arm),
		.key      (key),
		.crc_fail (crc_fail),
		.idle     (idle)
	);

	sd_host_model host_i
	(
		.iclk       (iclk),
		.host_dat   (sd_in),
		.card_lines (sd_out)
	);

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic key_t lfsr_next(key_t s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic check_value(input string what, input logic [31:0] want,
		input logic [31:0] got);
		checks++;
		assert (got == want) else
		begin
			errors++;
			$display("Error %s %s: expected %0h, actual %0h", test_name, what, want, got);
		end
	endtask

	//==================================================
	// Returned block against the keystream model
	//==================================================
	task automatic check_returned(input key_t k);
		key_t    ks;
		nibble_t want;
		ks = (k == '0) ? LFSR_ZERO_SEED : k;
		check_value("start nibble", 32'h0, 32'(host_i.rx_start));
		for (int n = 0; n < BLOCK_NIBBLES; n++)
		begin
			want = host_i.tx_block[n] ^ ks[3:0];
			check_value($sformatf("data %0d", n), 32'(want), 32'(host_i.rx_block[n]));
			ks = lfsr_next(ks);
		end
		for (int i = 0; i < 4; i++)
			check_value($sformatf("crc line %0d", i), 32'(host_i.calc_crc[i]),
				32'(host_i.rx_crc[i]));
		check_value("end nibble", 32'hF, 32'(host_i.rx_end));
		check_value("oe gaps", 32'h0, 32'(host_i.oe_drops));
		check_value("oe after block", 32'h0, 32'(host_i.oe_after));
	endtask

	// crc_fail must be clear once the start bit is taken
	task automatic watch_start_bit(input int limit);
		int waited;
		waited = 0;
		@(negedge iclk);
		while (idle && waited < limit)
		begin
			@(negedge iclk);
			waited++;
		end
		if (idle)
		begin
			errors++;
			$display("The DUT never left idle for the start bit in test %s", test_name);
		end
		else
			check_value("crc_fail at start bit", 32'h0, 32'(crc_fail));
	endtask

	task automatic good_block(input string name, input key_t k);
		test_name = name;
		@(posedge iclk);
		#2 key = k;
		host_i.fill_block(seed);
		fork
			host_i.send_block(-1);
			watch_start_bit(8);
		join
		host_i.capture_block(3000);
		if (host_i.timed_out)
		begin
			errors++;
			stop_run = 1'b1;
			$display("Timeout in test %s: no block came back from the DUT", test_name);
		end
		else
			check_returned(k);
	endtask

	task automatic bad_block();
		int waited;
		int oe_seen;
		test_name = "bad_crc";
		host_i.fill_block(seed);
		host_i.send_block(CRC_BITS - 1); // End bit follows, no false start
		waited = 0;
		while (!crc_fail && waited < 50)
		begin
			@(negedge iclk);
			waited++;
		end
		check_value("crc_fail", 32'h1, 32'(crc_fail));
		oe_seen = 0;
		for (int n = 0; n < 2 * BLOCK_NIBBLES; n++) // Longer than a cipher pass
		begin
			@(negedge iclk);
			if (sd_out.oe)
				oe_seen++;
		end
		check_value("oe cycles after crc error", 32'h0, 32'(oe_seen));
		check_value("idle", 32'h1, 32'(idle));
	endtask

	task automatic finish_run();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	initial
	begin
		key_t rand_key;
		errors   = 0;
		checks   = 0;
		stop_run = 1'b0;
		irst     = 1'b1;
		arm      = 1'b0;
		key      = '0;
		repeat (4) @(posedge iclk);
		#2 irst  = 1'b0;
		arm      = 1'b1;
		test_name = "reset";
		@(negedge iclk);
		check_value("oe", 32'h0, 32'(sd_out.oe));
		check_value("crc_fail", 32'h0, 32'(crc_fail));
		check_value("idle", 32'h1, 32'(idle));
		rand_key = key_t'($random(seed));
		if (rand_key == '0)
			rand_key = 16'h0001;
		good_block("good_block", rand_key);
		if (!stop_run)
			bad_block();
		if (!stop_run)
			good_block("zero_key", '0); // Seed falls back to the fixed value
		finish_run();
	end

endmodule

// ==== sd_crypt.f ====
design/sd_crypt_pkg.sv
design/crc16_line.sv
design/nibble_ram.sv
design/nibble_cipher.sv
design/sd_data_lines.sv
design/sd_crypt_top.sv
verif/sd_host_model.sv
verif/sd_crypt_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the SD crypt testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir build.log "$LOG"
verilator --binary --assert -f sd_crypt.f --top-module sd_crypt_tb > build.log 2>&1 \
	&& ./obj_dir/Vsd_crypt_tb > "$LOG" 2>&1 \
	|| { cat build.log "$LOG" 2>/dev/null; echo "FAIL: build or run error"; exit 1; }
cat "$LOG"
grep -q "Finished with errors" "$LOG" && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
